/* verilog/retire_pkg.sv */
package retire_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int WB_SEL_W    = 4;
    localparam int CSR_CMD_W   = 3;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // Writeback source select.
    localparam logic [WB_SEL_W-1:0] WB_ALU   = 4'd0;
    localparam logic [WB_SEL_W-1:0] WB_MEMB  = 4'd1;
    localparam logic [WB_SEL_W-1:0] WB_MEMBU = 4'd2;
    localparam logic [WB_SEL_W-1:0] WB_MEMH  = 4'd3;
    localparam logic [WB_SEL_W-1:0] WB_MEMHU = 4'd4;
    localparam logic [WB_SEL_W-1:0] WB_MEMW  = 4'd5;
    localparam logic [WB_SEL_W-1:0] WB_PC    = 4'd6;
    localparam logic [WB_SEL_W-1:0] WB_CSR   = 4'd7;

    // CSR commands; the last three are traps.
    localparam logic [CSR_CMD_W-1:0] CSR_NONE  = 3'd0;
    localparam logic [CSR_CMD_W-1:0] CSR_W     = 3'd1;
    localparam logic [CSR_CMD_W-1:0] CSR_S     = 3'd2;
    localparam logic [CSR_CMD_W-1:0] CSR_C     = 3'd3;
    localparam logic [CSR_CMD_W-1:0] CSR_ECALL = 3'd4;
    localparam logic [CSR_CMD_W-1:0] CSR_MRET  = 3'd5;
    localparam logic [CSR_CMD_W-1:0] CSR_SRET  = 3'd6;

    localparam logic [XLEN-1:0] EXIT_PC = 32'hffff_ff00;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [WB_SEL_W-1:0]   wb_sel;
        logic [CSR_CMD_W-1:0]  csr_cmd;
        logic [REG_ADDR_W-1:0] wb_addr;
        logic                  rf_wen;
        logic                  br_flg;
        logic [XLEN-1:0]       br_target;
        logic                  jmp_flg;
        logic [XLEN-1:0]       alu_out;
        logic [XLEN-1:0]       csr_rdata;
        logic [XLEN-1:0]       mem_rdata;
    } retire_req_t;

    typedef struct packed {
        logic [XLEN-1:0] next_pc;
        logic            hazard;
    } next_pc_t;

endpackage

/* verilog/retire_queue.sv */
`timescale 1ns/1ps

module retire_queue (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  retire_pkg::retire_req_t push_data_i,
    input  logic                    pop_i,
    output logic                    head_valid_o,
    output retire_pkg::retire_req_t head_o
);

    retire_pkg::retire_req_t entries [retire_pkg::QUEUE_DEPTH];

    logic [retire_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [retire_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [retire_pkg::QUEUE_PTR_W:0]   count;

    function automatic logic [retire_pkg::QUEUE_PTR_W-1:0] ptr_inc(
        input logic [retire_pkg::QUEUE_PTR_W-1:0] ptr
    );
        if (ptr == retire_pkg::QUEUE_PTR_W'(retire_pkg::QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[wr_ptr] <= push_data_i;
        end
    end

    assign head_valid_o = (count != '0);
    assign head_o       = entries[rd_ptr];

    // Sender credits must keep a full queue from seeing a push.
    a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
        push_i |-> (count != (retire_pkg::QUEUE_PTR_W + 1)'(retire_pkg::QUEUE_DEPTH)));

    // The stage pops only a valid head.
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
        pop_i |-> head_valid_o);

endmodule

/* verilog/wb_data_select.sv */
`timescale 1ns/1ps

module wb_data_select (
    input  retire_pkg::retire_req_t         req_i,
    output logic [retire_pkg::XLEN-1:0]     wb_data_o
);

    logic [retire_pkg::XLEN-1:0] pc_plus4;
    logic [7:0]                  load_byte;
    logic [15:0]                 load_half;

    assign pc_plus4  = req_i.pc + 32'd4;
    assign load_byte = req_i.mem_rdata[7:0];
    assign load_half = req_i.mem_rdata[15:0];

    always_comb begin
        case (req_i.wb_sel)
            retire_pkg::WB_MEMB: begin
                wb_data_o = {{24{load_byte[7]}}, load_byte};
            end
            retire_pkg::WB_MEMBU: begin
                wb_data_o = {24'd0, load_byte};
            end
            retire_pkg::WB_MEMH: begin
                wb_data_o = {{16{load_half[15]}}, load_half};
            end
            retire_pkg::WB_MEMHU: begin
                wb_data_o = {16'd0, load_half};
            end
            retire_pkg::WB_MEMW: begin
                wb_data_o = req_i.mem_rdata;
            end
            retire_pkg::WB_PC: begin
                wb_data_o = pc_plus4;
            end
            retire_pkg::WB_CSR: begin
                wb_data_o = req_i.csr_rdata;
            end
            // WB_ALU and unknown selects take the ALU result.
            default: begin
                wb_data_o = req_i.alu_out;
            end
        endcase
    end

endmodule

/* verilog/next_pc_unit.sv */
`timescale 1ns/1ps

module next_pc_unit (
    input  retire_pkg::retire_req_t     req_i,
    input  logic [retire_pkg::XLEN-1:0] trap_vector_i,
    output retire_pkg::next_pc_t        next_pc_o
);

    logic [retire_pkg::XLEN-1:0] pc_plus4;
    logic                        is_trap;

    assign pc_plus4 = req_i.pc + 32'd4;

    // Environment call and the two returns redirect to the trap vector.
    assign is_trap = (req_i.csr_cmd == retire_pkg::CSR_ECALL) ||
                     (req_i.csr_cmd == retire_pkg::CSR_MRET)  ||
                     (req_i.csr_cmd == retire_pkg::CSR_SRET);

    // Branch wins over jump, jump over trap.
    always_comb begin
        if (req_i.br_flg) begin
            next_pc_o.next_pc = req_i.br_target;
        end else if (req_i.jmp_flg) begin
            next_pc_o.next_pc = req_i.alu_out;
        end else if (is_trap) begin
            next_pc_o.next_pc = trap_vector_i;
        end else begin
            next_pc_o.next_pc = pc_plus4;
        end
    end

    // Any redirect flushes the younger stages.
    assign next_pc_o.hazard = req_i.br_flg || req_i.jmp_flg || is_trap;

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              we_i,
    input  logic [retire_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [retire_pkg::XLEN-1:0]       wdata_i,
    input  logic [retire_pkg::REG_ADDR_W-1:0] raddr_a_i,
    output logic [retire_pkg::XLEN-1:0]       rdata_a_o,
    input  logic [retire_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [retire_pkg::XLEN-1:0]       rdata_b_o
);

    logic [retire_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is hardwired.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // The write-back stage filters x0 before the write port.
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_i)
        we_i |-> (waddr_i != '0));

endmodule

/* verilog/write_back_stage.sv */
`timescale 1ns/1ps

module write_back_stage (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              head_valid_i,
    input  retire_pkg::retire_req_t           head_i,
    input  logic [retire_pkg::XLEN-1:0]       trap_vector_i,
    output logic                              pop_o,
    output logic                              rf_we_o,
    output logic [retire_pkg::REG_ADDR_W-1:0] rf_waddr_o,
    output logic [retire_pkg::XLEN-1:0]       rf_wdata_o,
    output logic                              next_pc_valid_o,
    output retire_pkg::next_pc_t              next_pc_o,
    output logic [31:0]                       retired_count_o,
    output logic                              halt_o
);

    retire_pkg::next_pc_t        next_pc;
    logic [retire_pkg::XLEN-1:0] wb_data;

    wb_data_select i_wb_data_select (
        .req_i     (head_i),
        .wb_data_o (wb_data)
    );

    next_pc_unit i_next_pc_unit (
        .req_i         (head_i),
        .trap_vector_i (trap_vector_i),
        .next_pc_o     (next_pc)
    );

    // Retire the head every cycle until halted.
    assign pop_o = head_valid_i && !halt_o;

    assign rf_we_o    = pop_o && head_i.rf_wen && (head_i.wb_addr != '0);
    assign rf_waddr_o = head_i.wb_addr;
    assign rf_wdata_o = wb_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            next_pc_valid_o <= 1'b0;
            retired_count_o <= '0;
            halt_o          <= 1'b0;
        end else begin
            next_pc_valid_o <= pop_o;
            if (pop_o) begin
                retired_count_o <= retired_count_o + 32'd1;
                // Exit packet still retires, halt is seen next cycle.
                if (head_i.pc == retire_pkg::EXIT_PC) begin
                    halt_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            next_pc_o <= next_pc;
        end
    end

endmodule

/* verilog/retire_top.sv */
`timescale 1ns/1ps

module retire_top (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              req_valid_i,
    input  retire_pkg::retire_req_t           req_i,
    output logic                              credit_o,
    input  logic [retire_pkg::XLEN-1:0]       trap_vector_i,
    input  logic [retire_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    output logic [retire_pkg::XLEN-1:0]       rs1_data_o,
    input  logic [retire_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [retire_pkg::XLEN-1:0]       rs2_data_o,
    output logic                              next_pc_valid_o,
    output retire_pkg::next_pc_t              next_pc_o,
    output logic [31:0]                       retired_count_o,
    output logic                              halt_o
);

    retire_pkg::retire_req_t           head;
    logic                              head_valid;
    logic                              pop;
    logic                              rf_we;
    logic [retire_pkg::REG_ADDR_W-1:0] rf_waddr;
    logic [retire_pkg::XLEN-1:0]       rf_wdata;

    // One credit returns per retired packet.
    assign credit_o = pop;

    retire_queue i_retire_queue (
        .clk          (clk),
        .rst_i        (rst_i),
        .push_i       (req_valid_i),
        .push_data_i  (req_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head)
    );

    write_back_stage i_write_back_stage (
        .clk             (clk),
        .rst_i           (rst_i),
        .head_valid_i    (head_valid),
        .head_i          (head),
        .trap_vector_i   (trap_vector_i),
        .pop_o           (pop),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .next_pc_valid_o (next_pc_valid_o),
        .next_pc_o       (next_pc_o),
        .retired_count_o (retired_count_o),
        .halt_o          (halt_o)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr_i),
        .rdata_a_o (rs1_data_o),
        .raddr_b_i (rs2_addr_i),
        .rdata_b_o (rs2_data_o)
    );

endmodule

/* testbench/tb_retire_top.sv */
`timescale 1ns/1ps

module tb_retire_top;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    // Credit burst 4, loads 10, sources 5, next PC 16, halt 3.
    localparam int TOTAL_PACKETS   = 38;
    localparam int WATCHDOG_CYCLES = TOTAL_PACKETS * 20 + RESET_CYCLES;
    localparam logic [31:0] TRAP_VECTOR = 32'h8000_0100;

    logic                    clk = 1'b0;
    logic                    rst_i;
    logic                    req_valid_i;
    retire_pkg::retire_req_t req_i;
    logic                    credit_o;
    logic [31:0]             trap_vector_i;
    logic [4:0]              rs1_addr_i;
    logic [31:0]             rs1_data_o;
    logic [4:0]              rs2_addr_i;
    logic [31:0]             rs2_data_o;
    logic                    next_pc_valid_o;
    retire_pkg::next_pc_t    next_pc_o;
    logic [31:0]             retired_count_o;
    logic                    halt_o;

    integer               seed = 81851;
    int                   errors = 0;
    int                   credits = retire_pkg::QUEUE_DEPTH;
    int                   credit_pulses = 0;
    int                   packets_sent = 0;
    int                   model_retired = 0;
    logic                 model_halted = 1'b0;
    logic [31:0]          model_regs [32];
    retire_pkg::next_pc_t exp_q [$];

    retire_top i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR time=%0t %s", $time, msg);
    endtask

    function automatic logic [31:0] random_pc();
        return $random(seed) & 32'h7fff_fffc;
    endfunction

    function automatic retire_pkg::retire_req_t make_packet(
        input logic [31:0] pc,
        input logic [3:0]  wb_sel,
        input logic [4:0]  addr,
        input logic        wen
    );
        retire_pkg::retire_req_t p;
        p.pc        = pc;
        p.wb_sel    = wb_sel;
        p.csr_cmd   = retire_pkg::CSR_NONE;
        p.wb_addr   = addr;
        p.rf_wen    = wen;
        p.br_flg    = 1'b0;
        p.br_target = $random(seed) & 32'hffff_fffc;
        p.jmp_flg   = 1'b0;
        p.alu_out   = $random(seed);
        p.csr_rdata = $random(seed);
        p.mem_rdata = $random(seed);
        return p;
    endfunction

    // Reference writeback value.
    function automatic logic [31:0] expected_wb(input retire_pkg::retire_req_t p);
        case (p.wb_sel)
            retire_pkg::WB_MEMB:  return {{24{p.mem_rdata[7]}}, p.mem_rdata[7:0]};
            retire_pkg::WB_MEMBU: return {24'd0, p.mem_rdata[7:0]};
            retire_pkg::WB_MEMH:  return {{16{p.mem_rdata[15]}}, p.mem_rdata[15:0]};
            retire_pkg::WB_MEMHU: return {16'd0, p.mem_rdata[15:0]};
            retire_pkg::WB_MEMW:  return p.mem_rdata;
            retire_pkg::WB_PC:    return p.pc + 32'd4;
            retire_pkg::WB_CSR:   return p.csr_rdata;
            default:              return p.alu_out;
        endcase
    endfunction

    function automatic retire_pkg::next_pc_t expected_next_pc(input retire_pkg::retire_req_t p);
        retire_pkg::next_pc_t r;
        logic                 trap;
        trap = p.csr_cmd inside {retire_pkg::CSR_ECALL, retire_pkg::CSR_MRET,
                                 retire_pkg::CSR_SRET};
        if (p.br_flg) begin
            r.next_pc = p.br_target;
        end else if (p.jmp_flg) begin
            r.next_pc = p.alu_out;
        end else if (trap) begin
            r.next_pc = TRAP_VECTOR;
        end else begin
            r.next_pc = p.pc + 32'd4;
        end
        r.hazard = p.br_flg | p.jmp_flg | trap;
        return r;
    endfunction

    // Credit return and next-PC pulses, sampled at the edge they belong to.
    always @(posedge clk) begin
        if (!rst_i) begin
            if (credit_o) begin
                credits++;
                credit_pulses++;
                if (credits > retire_pkg::QUEUE_DEPTH) begin
                    report_error("credit_o returned more credits than packets were sent");
                end
            end
            if (next_pc_valid_o) begin
                if (exp_q.size() == 0) begin
                    report_error("next_pc_valid_o pulsed with no retired packet pending");
                end else begin
                    if (next_pc_o.next_pc !== exp_q[0].next_pc) begin
                        report_mismatch("next_pc_o.next_pc", exp_q[0].next_pc,
                                        next_pc_o.next_pc);
                    end
                    if (next_pc_o.hazard !== exp_q[0].hazard) begin
                        report_mismatch("next_pc_o.hazard", {31'd0, exp_q[0].hazard},
                                        {31'd0, next_pc_o.hazard});
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    // Called on a falling edge; returns on the next one.
    task automatic send_packet(input retire_pkg::retire_req_t p);
        while (credits == 0) begin
            @(negedge clk);
        end
        req_i       = p;
        req_valid_i = 1'b1;
        credits--;
        packets_sent++;
        if (!model_halted) begin
            exp_q.push_back(expected_next_pc(p));
            model_retired++;
            if (p.rf_wen && p.wb_addr != 5'd0) begin
                model_regs[p.wb_addr] = expected_wb(p);
            end
            if (p.pc == retire_pkg::EXIT_PC) begin
                model_halted = 1'b1;
            end
        end
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    // Waits until every modeled packet has shown its next-PC pulse.
    task automatic wait_drain();
        int n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_error("sent packets did not all retire within 50 cycles");
        end
    endtask

    task automatic check_reg(input logic [4:0] addr);
        rs1_addr_i = addr;
        rs2_addr_i = addr;
        @(posedge clk);
        if (rs1_data_o !== model_regs[addr]) begin
            report_mismatch($sformatf("rs1_data_o(x%0d)", addr), model_regs[addr], rs1_data_o);
        end
        if (rs2_data_o !== model_regs[addr]) begin
            report_mismatch($sformatf("rs2_data_o(x%0d)", addr), model_regs[addr], rs2_data_o);
        end
        @(negedge clk);
    endtask

    task automatic test_credit_flow();
        int pulses_before;
        pulses_before = credit_pulses;
        for (int i = 0; i < retire_pkg::QUEUE_DEPTH; i++) begin
            send_packet(make_packet(random_pc(), retire_pkg::WB_ALU, 5'(i + 12), 1'b1));
        end
        wait_drain();
        if (credit_pulses - pulses_before != retire_pkg::QUEUE_DEPTH) begin
            report_mismatch("credit_o pulses", 32'(retire_pkg::QUEUE_DEPTH),
                            32'(credit_pulses - pulses_before));
        end
        if (retired_count_o !== 32'(model_retired)) begin
            report_mismatch("retired_count_o", 32'(model_retired), retired_count_o);
        end
        check_reg(5'd12);
    endtask

    task automatic test_load_extension();
        logic [3:0]              codes [5];
        retire_pkg::retire_req_t p;
        codes[0] = retire_pkg::WB_MEMB;
        codes[1] = retire_pkg::WB_MEMBU;
        codes[2] = retire_pkg::WB_MEMH;
        codes[3] = retire_pkg::WB_MEMHU;
        codes[4] = retire_pkg::WB_MEMW;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 5; k++) begin
                p = make_packet(random_pc(), codes[k], 5'(k + 1), 1'b1);
                // Byte and halfword sign bits set in round 0, clear in round 1.
                if (round == 0) begin
                    p.mem_rdata = p.mem_rdata | 32'h0000_8080;
                end else begin
                    p.mem_rdata = p.mem_rdata & 32'hffff_7f7f;
                end
                send_packet(p);
                wait_drain();
                check_reg(5'(k + 1));
            end
        end
    endtask

    task automatic test_wb_sources();
        send_packet(make_packet(random_pc(), retire_pkg::WB_PC, 5'd6, 1'b1));
        send_packet(make_packet(random_pc(), retire_pkg::WB_CSR, 5'd7, 1'b1));
        // Code 12 is unassigned.
        send_packet(make_packet(random_pc(), 4'd12, 5'd8, 1'b1));
        send_packet(make_packet(random_pc(), retire_pkg::WB_ALU, 5'd6, 1'b0));
        send_packet(make_packet(random_pc(), retire_pkg::WB_ALU, 5'd0, 1'b1));
        wait_drain();
        check_reg(5'd0);
        check_reg(5'd6);
        check_reg(5'd7);
        check_reg(5'd8);
        if (retired_count_o !== 32'(model_retired)) begin
            report_mismatch("retired_count_o", 32'(model_retired), retired_count_o);
        end
    endtask

    task automatic test_next_pc_priority();
        logic [2:0]              cmds [4];
        retire_pkg::retire_req_t p;
        cmds[0] = retire_pkg::CSR_W;
        cmds[1] = retire_pkg::CSR_ECALL;
        cmds[2] = retire_pkg::CSR_MRET;
        cmds[3] = retire_pkg::CSR_SRET;
        for (int i = 0; i < 16; i++) begin
            p = make_packet(random_pc(), retire_pkg::WB_ALU, 5'd0, 1'b0);
            p.br_flg  = i[0];
            p.jmp_flg = i[1];
            p.csr_cmd = cmds[i / 4];
            send_packet(p);
        end
        wait_drain();
    endtask

    task automatic test_halt();
        int          pulses_before;
        logic [31:0] count_before;
        int          n = 0;
        send_packet(make_packet(retire_pkg::EXIT_PC, retire_pkg::WB_ALU, 5'd9, 1'b1));
        send_packet(make_packet(random_pc(), retire_pkg::WB_ALU, 5'd10, 1'b1));
        send_packet(make_packet(random_pc(), retire_pkg::WB_ALU, 5'd11, 1'b1));
        while (!halt_o && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!halt_o) begin
            report_error("halt_o did not rise after the exit packet retired");
        end
        pulses_before = credit_pulses;
        count_before  = retired_count_o;
        repeat (20) @(negedge clk);
        if (credit_pulses != pulses_before) begin
            report_error("credit_o pulsed while the subsystem was halted");
        end
        if (retired_count_o !== count_before || retired_count_o !== 32'(model_retired)) begin
            report_mismatch("retired_count_o", 32'(model_retired), retired_count_o);
        end
        if (halt_o !== 1'b1) begin
            report_mismatch("halt_o", 32'd1, {31'd0, halt_o});
        end
        if (exp_q.size() != 0) begin
            report_error("exit packet produced no next_pc_valid_o pulse");
        end
        check_reg(5'd9);
        check_reg(5'd10);
        check_reg(5'd11);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_i         = 1'b1;
        req_valid_i   = 1'b0;
        req_i         = '0;
        trap_vector_i = TRAP_VECTOR;
        rs1_addr_i    = 5'd0;
        rs2_addr_i    = 5'd0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        if (retired_count_o !== 32'd0) begin
            report_mismatch("retired_count_o", 32'd0, retired_count_o);
        end
        if (halt_o !== 1'b0) begin
            report_mismatch("halt_o", 32'd0, {31'd0, halt_o});
        end
        if (credit_o !== 1'b0) begin
            report_mismatch("credit_o", 32'd0, {31'd0, credit_o});
        end
        if (next_pc_valid_o !== 1'b0) begin
            report_mismatch("next_pc_valid_o", 32'd0, {31'd0, next_pc_valid_o});
        end

        test_credit_flow();
        test_load_extension();
        test_wb_sources();
        test_next_pc_priority();
        test_halt();

        $display("Summary: %0d packets sent, %0d retired, %0d errors",
                 packets_sent, model_retired, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/retire_pkg.sv
verilog/retire_queue.sv
verilog/wb_data_select.sv
verilog/next_pc_unit.sv
verilog/reg_file.sv
verilog/write_back_stage.sv
verilog/retire_top.sv
testbench/tb_retire_top.sv

/* run.sh */
#!/bin/sh
# Build and run the retire subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_retire_top \
    -f list.f \
    -o sim_retire

./obj_dir/sim_retire > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run.sh: testbench reported failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "run.sh: simulation ended without a result"
    exit 1
fi
echo "run.sh: testbench reported success"
